// File: sim.f
source/ph_fp_pkg.sv
source/ph_axil_pkg.sv
source/ph_const_rom.sv
source/ph_mac.sv
source/ph_sequencer.sv
source/ph_regs.sv
source/ph_reduce_top.sv
tb/tb_ph_reduce.sv

// File: Bender.yml
package:
  name: ph_reduce

sources:
  - source/ph_fp_pkg.sv
  - source/ph_axil_pkg.sv
  - source/ph_const_rom.sv
  - source/ph_mac.sv
  - source/ph_sequencer.sv
  - source/ph_regs.sv
  - source/ph_reduce_top.sv
  - target: test
    files:
      - tb/tb_ph_reduce.sv

// File: tb/tb_ph_reduce.sv
// Expects ADDR_W of 8 and the ROM's 256-bit 2/pi table, one argument in flight at a time
module tb_ph_reduce;
    timeunit 1ns;
    timeprecision 1ps;

    import ph_fp_pkg::*;
    import ph_axil_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int N_RANDOM = 30;
    // About 40 operations of about 60 cycles, with margin
    localparam int N_OPS      = 40;
    localparam int OP_CYCLES  = 60;
    localparam int MAX_CYCLES = N_OPS * OP_CYCLES * 5 / 2;

    // 2/pi table, most significant chunk first
    localparam logic [255:0] TWO_OVER_PI =
        256'hA2F9836E4E441529_FC2757D1F534DDC0_DB6295993C439041_FE5163ABDEBBC561;
    // pi/2 mantissa, Q1.63
    localparam logic [63:0] PIO2_MANT = 64'hC90F_DAA2_2168_C235;

    logic       clk;
    logic       arst_n;
    axil_req_t  bus_req;
    axil_rsp_t  bus_rsp;
    logic [63:0] rng_state = 64'd69782;
    int          cycle_count = 0;

    ph_reduce_top #(
        .ADDR_W(8)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            report_failure($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                                     $time, name, exp_v, act_v));
        end
    endtask

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 7;
        x ^= x << 17;
        return x;
    endfunction

    // Wide product, then fields picked bit by bit around the binary point
    function automatic ph_result_t reference_reduce(input logic [63:0] m, input int e);
        logic [320:0] p;
        logic [127:0] prod;
        ph_result_t   r;
        int           i;
        p = 321'(m) * 321'(TWO_OVER_PI);
        r.quad = {p[320-e], p[319-e]};
        for (i = 0; i < 64; i++) begin
            r.frac[i] = p[255-e+i];
        end
        prod = 128'(r.frac) * 128'(PIO2_MANT);
        r.reduced = prod[127:64];
        return r;
    endfunction

    // ====================
    // AXI4-Lite host
    // ====================

    // Stall holds bready low for that many cycles once bvalid is up
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input int stall, output logic [1:0] resp);
        @(posedge clk);
        bus_req.awaddr  <= addr;
        bus_req.awvalid <= 1'b1;
        bus_req.wdata   <= data;
        bus_req.wstrb   <= 4'hF;
        bus_req.wvalid  <= 1'b1;
        bus_req.bready  <= (stall == 0);
        do @(negedge clk); while (!(bus_rsp.awready && bus_rsp.wready));
        // Taken on this edge
        @(posedge clk);
        bus_req.awvalid <= 1'b0;
        bus_req.wvalid  <= 1'b0;
        do @(negedge clk); while (!bus_rsp.bvalid);
        resp = bus_rsp.bresp;
        if (stall > 0) begin
            repeat (stall) @(negedge clk);
            @(posedge clk);
            bus_req.bready <= 1'b1;
        end
        @(posedge clk);
        bus_req.bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        bus_req.araddr  <= addr;
        bus_req.arvalid <= 1'b1;
        bus_req.rready  <= (stall == 0);
        do @(negedge clk); while (!bus_rsp.arready);
        @(posedge clk);
        bus_req.arvalid <= 1'b0;
        do @(negedge clk); while (!bus_rsp.rvalid);
        data = bus_rsp.rdata;
        resp = bus_rsp.rresp;
        if (stall > 0) begin
            repeat (stall) @(negedge clk);
            @(posedge clk);
            bus_req.rready <= 1'b1;
        end
        @(posedge clk);
        bus_req.rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        bus_write(addr, data, 0, resp);
        check_value("bresp", AXIL_OKAY, resp);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        bus_read(addr, 0, data, resp);
        check_value("rresp", AXIL_OKAY, resp);
    endtask

    // Poll STATUS until the done bit, noting whether busy showed on the way
    task automatic wait_done(output logic [31:0] status, output logic saw_busy);
        status   = '0;
        saw_busy = 1'b0;
        while (!status[1]) begin
            read_reg(STATUS, status);
            saw_busy = saw_busy | status[0];
        end
    endtask

    task automatic run_op(input logic [63:0] mant, input logic [14:0] exp_v,
                          output logic [31:0] status, output logic saw_busy);
        write_reg(ARG_LO, mant[31:0]);
        write_reg(ARG_HI, mant[63:32]);
        write_reg(ARG_EXP, 32'(exp_v));
        write_reg(CTRL, 32'h1);
        wait_done(status, saw_busy);
    endtask

    task automatic read_results(output ph_result_t r);
        logic [31:0] lo;
        logic [31:0] hi;
        read_reg(QUAD, lo);
        r.quad = lo[1:0];
        read_reg(FRAC_LO, lo);
        read_reg(FRAC_HI, hi);
        r.frac = {hi, lo};
        read_reg(RED_LO, lo);
        read_reg(RED_HI, hi);
        r.reduced = {hi, lo};
    endtask

    task automatic check_result(input ph_result_t want, input ph_result_t got);
        check_value("QUAD", want.quad, got.quad);
        check_value("FRAC", want.frac, got.frac);
        check_value("RED", want.reduced, got.reduced);
    endtask

    // ====================
    // Bus checks
    // ====================

    assert property (@(posedge clk) !arst_n |->
        !bus_rsp.bvalid && !bus_rsp.rvalid && bus_rsp.awready && bus_rsp.wready
        && bus_rsp.arready)
        else report_failure("Bus outputs not in their reset state during reset");
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp))
        else report_failure("Write response dropped or changed before bready");
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.rvalid && !bus_req.rready |=>
        bus_rsp.rvalid && $stable(bus_rsp.rdata) && $stable(bus_rsp.rresp))
        else report_failure("Read response dropped or changed before rready");
    // No new address while a response waits
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.bvalid |-> !bus_rsp.awready && !bus_rsp.wready)
        else report_failure("Write address ready while a write response is pending");
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.rvalid |-> !bus_rsp.arready)
        else report_failure("Read address ready while a read response is pending");

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            report_failure($sformatf("Timeout after %0d clock cycles", MAX_CYCLES));
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        logic [31:0] rdata;
        logic [1:0]  resp;
        logic [63:0] mant;
        int          exp_v;
        int          n;
        logic        saw_busy;
        ph_result_t  want;
        ph_result_t  got;
        ph_result_t  last;

        bus_req = '0;
        arst_n  = 1'b1;
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("bvalid", 1'b0, bus_rsp.bvalid);
        check_value("rvalid", 1'b0, bus_rsp.rvalid);
        read_reg(STATUS, rdata);
        check_value("STATUS", 32'h0, rdata);

        // Random reductions, edge exponents first
        for (n = 0; n < N_RANDOM; n++) begin
            rng_state = xorshift64(rng_state);
            mant = rng_state;
            rng_state = xorshift64(rng_state);
            if (n == 0) begin
                exp_v = 0;
            end else if (n == 1) begin
                exp_v = EXP_MAX;
            end else begin
                exp_v = int'(rng_state[6:0]);
            end
            run_op(mant, 15'(exp_v), rdata, saw_busy);
            check_value("STATUS", 32'h2, rdata);
            // First poll lands well inside the 8-cycle run
            check_value("STATUS.busy", 1'b1, saw_busy);
            want = reference_reduce(mant, exp_v);
            read_results(got);
            check_result(want, got);
        end
        last = want;

        // Out of range, results keep the last good values
        rng_state = xorshift64(rng_state);
        run_op(rng_state, 15'(EXP_MAX + 1), rdata, saw_busy);
        check_value("STATUS", 32'h6, rdata);
        check_value("STATUS.busy", 1'b0, saw_busy);
        read_results(got);
        check_result(last, got);
        run_op(rng_state, 15'h7FFF, rdata, saw_busy);
        check_value("STATUS", 32'h6, rdata);
        check_value("STATUS.busy", 1'b0, saw_busy);

        // Argument and start writes land while the engine runs
        rng_state = xorshift64(rng_state);
        mant = rng_state;
        rng_state = xorshift64(rng_state);
        exp_v = int'(rng_state[6:0]);
        write_reg(ARG_LO, mant[31:0]);
        write_reg(ARG_HI, mant[63:32]);
        write_reg(ARG_EXP, 32'(exp_v));
        write_reg(CTRL, 32'h1);
        write_reg(ARG_LO, ~mant[31:0]);
        write_reg(CTRL, 32'h1);
        wait_done(rdata, saw_busy);
        check_value("STATUS", 32'h2, rdata);
        want = reference_reduce(mant, exp_v);
        read_results(got);
        check_result(want, got);
        read_reg(ARG_LO, rdata);
        check_value("ARG_LO", mant[31:0], rdata);

        // Unmapped and misaligned addresses
        bus_write(32'h28, 32'hDEAD_BEEF, 0, resp);
        check_value("bresp", AXIL_SLVERR, resp);
        bus_read(32'h28, 0, rdata, resp);
        check_value("rresp", AXIL_SLVERR, resp);
        check_value("rdata", 32'h0, rdata);
        bus_read(32'h06, 0, rdata, resp);
        check_value("rresp", AXIL_SLVERR, resp);
        check_value("rdata", 32'h0, rdata);

        // Responses held back by the host
        bus_write(32'h2C, 32'h1234_5678, 4, resp);
        check_value("bresp", AXIL_SLVERR, resp);
        bus_write(ARG_EXP, 32'h55, 6, resp);
        check_value("bresp", AXIL_OKAY, resp);
        bus_read(ARG_EXP, 6, rdata, resp);
        check_value("rresp", AXIL_OKAY, resp);
        check_value("ARG_EXP", 32'h55, rdata);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: source/ph_reduce_top.sv
// Payne-Hanek reduction unit behind AXI4-Lite, host polls STATUS since there is no interrupt
module ph_reduce_top #(
    parameter int ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  ph_axil_pkg::axil_req_t  bus_req,
    output ph_axil_pkg::axil_rsp_t  bus_rsp
);
    import ph_fp_pkg::*;

    // Register block to engine
    logic       start;
    ph_arg_t    arg;
    logic       busy;
    logic       done;
    logic       range_err;
    ph_result_t result;

    // Microcode controls
    rom_addr_e        rom_addr;
    logic [ROM_W-1:0] rom_data;
    logic             acc_clear;
    logic             acc_step;
    logic             extract;
    logic             pi_step;

    ph_regs #(
        .ADDR_W(ADDR_W)
    ) u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .start     (start),
        .arg       (arg),
        .busy      (busy),
        .done      (done),
        .range_err (range_err),
        .result    (result)
    );

    ph_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .arg_exp   (arg.exp),
        .busy      (busy),
        .done      (done),
        .range_err (range_err),
        .rom_addr  (rom_addr),
        .acc_clear (acc_clear),
        .acc_step  (acc_step),
        .extract   (extract),
        .pi_step   (pi_step)
    );

    ph_mac u_mac (
        .clk       (clk),
        .arst_n    (arst_n),
        .mant      (arg.mant),
        .exp       (arg.exp),
        .rom_data  (rom_data),
        .acc_clear (acc_clear),
        .acc_step  (acc_step),
        .extract   (extract),
        .pi_step   (pi_step),
        .result    (result)
    );

    ph_const_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

// File: source/ph_regs.sv
// AXI4-Lite register slave, needs ADDR_W of 6 to 32 and ignores address bits above ADDR_W
module ph_regs #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  ph_axil_pkg::axil_req_t    bus_req,
    output ph_axil_pkg::axil_rsp_t    bus_rsp,
    output logic                      start,
    output ph_fp_pkg::ph_arg_t        arg,
    input  logic                      busy,
    input  logic                      done,
    input  logic                      range_err,
    input  ph_fp_pkg::ph_result_t     result
);
    import ph_fp_pkg::*;
    import ph_axil_pkg::*;

    logic                   bvalid_q;
    logic                   rvalid_q;
    logic [1:0]             bresp_q;
    logic [1:0]             rresp_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    // Sticky status, cleared by start
    logic                   done_q;
    logic                   err_q;
    ph_result_t             res_q;
    logic [ADDR_W-1:0]      waddr;
    logic [ADDR_W-1:0]      raddr;
    logic                   wr_fire;
    logic                   rd_fire;
    logic [AXIL_DATA_W-1:0] wr_word;
    logic [AXIL_DATA_W-1:0] rd_val;

    // Word-aligned offsets up to RED_HI
    function automatic logic in_map(input logic [ADDR_W-1:0] a);
        return (a[1:0] == 2'b00) && (a <= ADDR_W'(RED_HI));
    endfunction

    // Current register contents, CTRL reads as zero
    function automatic logic [AXIL_DATA_W-1:0] reg_value(input logic [ADDR_W-1:0] a);
        logic [AXIL_DATA_W-1:0] v;
        case (a)
            ADDR_W'(STATUS):  v = AXIL_DATA_W'({err_q, done_q, busy});
            ADDR_W'(ARG_LO):  v = arg.mant[31:0];
            ADDR_W'(ARG_HI):  v = arg.mant[63:32];
            ADDR_W'(ARG_EXP): v = AXIL_DATA_W'(arg.exp);
            ADDR_W'(QUAD):    v = AXIL_DATA_W'(res_q.quad);
            ADDR_W'(FRAC_LO): v = res_q.frac[31:0];
            ADDR_W'(FRAC_HI): v = res_q.frac[63:32];
            ADDR_W'(RED_LO):  v = res_q.reduced[31:0];
            ADDR_W'(RED_HI):  v = res_q.reduced[63:32];
            default:          v = '0;
        endcase
        return v;
    endfunction

    // Byte lanes without a strobe keep the old value
    function automatic logic [AXIL_DATA_W-1:0] merge_strb(
        input logic [AXIL_DATA_W-1:0] old_w,
        input logic [AXIL_DATA_W-1:0] new_w,
        input logic [AXIL_STRB_W-1:0] strb
    );
        logic [AXIL_DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < AXIL_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign waddr = bus_req.awaddr[ADDR_W-1:0];
    assign raddr = bus_req.araddr[ADDR_W-1:0];
    // AW and W are taken together, one outstanding response per channel
    assign wr_fire = bus_req.awvalid && bus_req.wvalid && !bvalid_q;
    assign rd_fire = bus_req.arvalid && !rvalid_q;

    always_comb begin
        wr_word = merge_strb(reg_value(waddr), bus_req.wdata, bus_req.wstrb);
        rd_val  = in_map(raddr) ? reg_value(raddr) : '0;
    end

    always_comb begin
        bus_rsp.awready = !bvalid_q;
        bus_rsp.wready  = !bvalid_q;
        bus_rsp.bresp   = bresp_q;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.arready = !rvalid_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = rresp_q;
        bus_rsp.rvalid  = rvalid_q;
    end

    // ====================
    // Write channel and status
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= AXIL_OKAY;
            start    <= 1'b0;
            arg      <= '0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
            res_q    <= '0;
        end else begin
            start <= 1'b0;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= in_map(waddr) ? AXIL_OKAY : AXIL_SLVERR;
                // Start and argument writes are dropped while busy
                case (waddr)
                    ADDR_W'(CTRL):    start         <= wr_word[0] && !busy;
                    ADDR_W'(ARG_LO):  if (!busy) arg.mant[31:0]  <= wr_word;
                    ADDR_W'(ARG_HI):  if (!busy) arg.mant[63:32] <= wr_word;
                    ADDR_W'(ARG_EXP): if (!busy) arg.exp <= wr_word[EXP_W-1:0];
                    default: ;
                endcase
            end else if (bvalid_q && bus_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (start) begin
                done_q <= 1'b0;
                err_q  <= 1'b0;
            end
            if (done) begin
                done_q <= 1'b1;
                err_q  <= range_err;
                // Old results survive a range error
                if (!range_err) begin
                    res_q <= result;
                end
            end
        end
    end

    // ====================
    // Read channel
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
            rresp_q  <= AXIL_OKAY;
            rdata_q  <= '0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rresp_q  <= in_map(raddr) ? AXIL_OKAY : AXIL_SLVERR;
            rdata_q  <= rd_val;
        end else if (rvalid_q && bus_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Responses hold until the host takes them
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp));
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_rsp.rvalid && !bus_req.rready |=> bus_rsp.rvalid && $stable(bus_rsp.rdata));

endmodule

// File: source/ph_sequencer.sv
// Reduction FSM with fixed 8-cycle latency, one argument at a time and no abort
module ph_sequencer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic [ph_fp_pkg::EXP_W-1:0]   arg_exp,
    output logic                          busy,
    output logic                          done,
    output logic                          range_err,
    output ph_fp_pkg::rom_addr_e          rom_addr,
    output logic                          acc_clear,
    output logic                          acc_step,
    output logic                          extract,
    output logic                          pi_step
);
    import ph_fp_pkg::*;

    seq_state_e state;
    // Index of the chunk being addressed
    logic [1:0] chunk;
    logic       arg_ok;

    assign arg_ok = arg_exp <= EXP_W'(EXP_MAX);
    assign busy   = state != IDLE;

    // ====================
    // Microcode outputs
    // ====================

    // Each acc_step consumes the address of the cycle before
    always_comb begin
        rom_addr  = PI_OVER_2;
        acc_clear = 1'b0;
        acc_step  = 1'b0;
        extract   = 1'b0;
        pi_step   = 1'b0;
        case (state)
            IDLE: begin
                // CHUNK0 is prefetched while waiting
                rom_addr  = CHUNK0;
                acc_clear = start && arg_ok;
            end
            MUL_CHUNK: begin
                rom_addr = rom_addr_e'({1'b0, chunk});
                acc_step = 1'b1;
            end
            // Last chunk lands here
            DRAIN:   acc_step = 1'b1;
            EXTRACT: extract  = 1'b1;
            MUL_PI:  pi_step  = 1'b1;
            default: ;
        endcase
    end

    // ====================
    // State register
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            chunk     <= '0;
            done      <= 1'b0;
            range_err <= 1'b0;
        end else begin
            done      <= 1'b0;
            range_err <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && arg_ok) begin
                        state <= MUL_CHUNK;
                        chunk <= 2'd1;
                    end else if (start) begin
                        // Out of table range
                        done      <= 1'b1;
                        range_err <= 1'b1;
                    end
                end
                MUL_CHUNK: begin
                    if (chunk == 2'd3) begin
                        state <= DRAIN;
                    end
                    chunk <= chunk + 2'd1;
                end
                DRAIN:   state <= EXTRACT;
                EXTRACT: state <= MUL_PI;
                MUL_PI:  state <= FINISH;
                FINISH: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> rom_addr inside {CHUNK0, CHUNK1, CHUNK2, CHUNK3, PI_OVER_2});

    // Full reduction takes exactly eight cycles
    assert property (@(posedge clk) disable iff (!arst_n)
        state == IDLE && start && arg_ok |-> ##8 (done && !range_err));

endmodule

// File: source/ph_mac.sv
// Shared 64x64 multiplier and 320-bit accumulator, valid only for exponents the sequencer accepts
module ph_mac (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [ph_fp_pkg::MANT_W-1:0]  mant,
    input  logic [ph_fp_pkg::EXP_W-1:0]   exp,
    input  logic [ph_fp_pkg::ROM_W-1:0]   rom_data,
    input  logic                          acc_clear,
    input  logic                          acc_step,
    input  logic                          extract,
    input  logic                          pi_step,
    output ph_fp_pkg::ph_result_t         result
);
    import ph_fp_pkg::*;

    logic [ACC_W-1:0]    acc;
    logic [MANT_W-1:0]   mul_a;
    logic [2*MANT_W-1:0] prod;
    // One spare zero bit above P so the top quadrant bit reads 0 at e = 0
    logic [ACC_W:0]      p_shift;

    // Multiplier shared between the 2/pi pass and the pi/2 pass
    assign mul_a = pi_step ? result.frac : mant;
    assign prod  = mul_a * rom_data[MANT_W-1:0];

    // Binary point of x*2/pi lands between bits 319-e and 318-e
    assign p_shift = {1'b0, acc} << exp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            result <= '0;
        end else begin
            if (acc_clear) begin
                acc <= '0;
            end else if (acc_step) begin
                // Chunks arrive most significant first
                acc <= (acc << MANT_W) + ACC_W'(prod);
            end
            if (extract) begin
                result.quad <= p_shift[ACC_W -: 2];
                result.frac <= p_shift[ACC_W-2 -: MANT_W];
            end
            // Q0.64 times Q1.63 keeps the upper half as Q1.63
            if (pi_step) begin
                result.reduced <= prod[2*MANT_W-1 -: MANT_W];
            end
        end
    end

    // Sequencer never overlaps clear and step
    assert property (@(posedge clk) disable iff (!arst_n) !(acc_clear && acc_step));

    // pi/2 must already be on the ROM output when the final multiply runs
    assert property (@(posedge clk) disable iff (!arst_n)
        pi_step |-> rom_data[ROM_W-1:MANT_W] == 16'h3FFF);

endmodule

// File: source/ph_const_rom.sv
// Constant ROM with one cycle of latency and 256 bits of 2/pi, so exponents beyond 127 lose bits
module ph_const_rom (
    input  logic                         clk,
    input  ph_fp_pkg::rom_addr_e         addr,
    output logic [ph_fp_pkg::ROM_W-1:0]  data
);
    import ph_fp_pkg::*;

    // ====================
    // 2/pi table
    // ====================

    // 2/pi = 0.A2F9836E4E44... in hex, split into 64-bit words
    localparam logic [MANT_W-1:0] TWO_PI_C0 = 64'hA2F9_836E_4E44_1529;
    localparam logic [MANT_W-1:0] TWO_PI_C1 = 64'hFC27_57D1_F534_DDC0;
    localparam logic [MANT_W-1:0] TWO_PI_C2 = 64'hDB62_9599_3C43_9041;
    // Least significant word
    localparam logic [MANT_W-1:0] TWO_PI_C3 = 64'hFE51_63AB_DEBB_C561;

    // pi/2 in FP80
    // Exponent 0x3FFF with explicit integer bit
    localparam logic [ROM_W-1:0] PIO2_FP80 = 80'h3FFF_C90F_DAA2_2168_C235;

    // Zero-extension of a table word
    localparam int PAD_W = ROM_W - MANT_W;

    // ====================
    // Registered read
    // ====================

    always_ff @(posedge clk) begin
        case (addr)
            CHUNK0:    data <= {{PAD_W{1'b0}}, TWO_PI_C0};
            CHUNK1:    data <= {{PAD_W{1'b0}}, TWO_PI_C1};
            CHUNK2:    data <= {{PAD_W{1'b0}}, TWO_PI_C2};
            CHUNK3:    data <= {{PAD_W{1'b0}}, TWO_PI_C3};
            PI_OVER_2: data <= PIO2_FP80;
            // Codes 5 to 7 are unused
            default:   data <= '0;
        endcase
    end

endmodule

// File: source/ph_axil_pkg.sv
// AXI4-Lite bus types and register map with 32-bit data and addresses decoded by the slave
package ph_axil_pkg;

    // ====================
    // Bus widths
    // ====================

    // Full bus address, the slave decodes only its low ADDR_W bits
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    // Response codes
    localparam logic [1:0] AXIL_OKAY   = 2'b00;
    localparam logic [1:0] AXIL_SLVERR = 2'b10;

    // Byte offsets, all word aligned and contiguous
    typedef enum logic [7:0] {
        CTRL    = 8'h00,
        STATUS  = 8'h04,
        ARG_LO  = 8'h08,
        ARG_HI  = 8'h0C,
        ARG_EXP = 8'h10,
        QUAD    = 8'h14,
        FRAC_LO = 8'h18,
        FRAC_HI = 8'h1C,
        RED_LO  = 8'h20,
        RED_HI  = 8'h24
    } reg_addr_e;

    // ====================
    // Channel bundles
    // ====================

    // Master side
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Slave side
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

// File: source/ph_fp_pkg.sv
// Reduction widths and engine types. Exponents above EXP_MAX are rejected and sign is not handled
package ph_fp_pkg;

    // ====================
    // Widths
    // ====================

    // Argument mantissa, integer form of m
    localparam int MANT_W = 64;
    localparam int EXP_W  = 15;
    // Largest exponent the 256-bit 2/pi table covers
    localparam int EXP_MAX = 127;
    // 64-bit mantissa times 256 bits of 2/pi
    localparam int ACC_W = 320;
    // Constant ROM word, sized for an FP80 value
    localparam int ROM_W = 80;

    // ====================
    // Encodings
    // ====================

    // Chunk 0 is the most significant 64 bits of 2/pi
    typedef enum logic [2:0] {
        CHUNK0    = 3'd0,
        CHUNK1    = 3'd1,
        CHUNK2    = 3'd2,
        CHUNK3    = 3'd3,
        PI_OVER_2 = 3'd4
    } rom_addr_e;

    typedef enum logic [2:0] {
        IDLE,
        MUL_CHUNK,
        DRAIN,
        EXTRACT,
        MUL_PI,
        FINISH
    } seq_state_e;

    // x = mant * 2^(exp - 63)
    typedef struct packed {
        logic [MANT_W-1:0] mant;
        logic [EXP_W-1:0]  exp;
    } ph_arg_t;

    // Reduced argument is Q1.63
    typedef struct packed {
        logic [1:0]        quad;
        logic [MANT_W-1:0] frac;
        logic [MANT_W-1:0] reduced;
    } ph_result_t;

endpackage
